// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_top_tb
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dcache_top.f
+incdir+include
logic/cache_pkg.sv
logic/mem_bus_pkg.sv
logic/refill_if.sv
logic/miss_table.sv
logic/cache_array.sv
logic/mem_port.sv
logic/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_top_tb.sv

// File: dv/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input wire logic                      clock,
    input wire logic                      reset,
    input wire logic                      req_valid,
    input wire logic                      req_accept,
    input wire logic                      hit_valid,
    input wire logic                      miss_resp_valid,
    input wire mem_bus_pkg::mem_tag_t     mem_data_tag,
    input wire mem_bus_pkg::mem_command_e mem_command
);

    accept_needs_valid: assert property (@(posedge clock) disable iff (reset)
        req_accept |-> req_valid)
        else $error("req_accept without req_valid");

    hit_needs_accept: assert property (@(posedge clock) disable iff (reset)
        hit_valid |-> req_accept)
        else $error("hit_valid without req_accept");

    // a miss result only comes out of a fill
    resp_needs_data_tag: assert property (@(posedge clock) disable iff (reset)
        miss_resp_valid |-> mem_data_tag != '0)
        else $error("miss_resp_valid with a zero data tag");

    // a second store in a row needs a fill that brought in another victim
    single_store: assert property (@(posedge clock) disable iff (reset)
        mem_command == mem_bus_pkg::cmd_store && mem_data_tag == '0 |=>
            mem_command != mem_bus_pkg::cmd_store)
        else $error("store command repeated without a new victim");

endmodule

bind dcache_top dcache_checker checker0 (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_accept(req_accept),
    .hit_valid(hit_valid),
    .miss_resp_valid(miss_resp_valid),
    .mem_data_tag(mem_data_tag),
    .mem_command(mem_command)
);

`default_nettype wire

// File: dv/dcache_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top_tb;

    localparam int directed_requests = 26;
    localparam int random_requests   = 400;
    localparam int cycle_limit       = 40 * (directed_requests + random_requests);
    localparam int tag_count         = 2 ** `DCACHE_MEM_TAG_BITS;

    logic                      clock;
    logic                      reset;
    logic                      req_valid;
    logic                      req_store;
    mem_bus_pkg::mem_size_e    req_size;
    mem_bus_pkg::addr_t        req_addr;
    mem_bus_pkg::word_t        req_data;
    cache_pkg::req_id_t        req_id;
    logic                      req_accept;
    logic                      hit_valid;
    mem_bus_pkg::word_t        hit_data;
    logic                      miss_resp_valid;
    cache_pkg::req_id_t        miss_resp_id;
    mem_bus_pkg::word_t        miss_resp_data;
    mem_bus_pkg::mem_command_e mem_command;
    mem_bus_pkg::addr_t        mem_addr;
    mem_bus_pkg::block_t       mem_wdata;
    mem_bus_pkg::mem_tag_t     mem_resp_tag;
    mem_bus_pkg::mem_tag_t     mem_data_tag;
    mem_bus_pkg::block_t       mem_data;

    integer                    seed;
    int                        cycle;
    int                        refusals;
    int                        refusals_before;
    logic                      want_hit;
    cache_pkg::req_id_t        next_id;
    logic [7:0]                golden [mem_bus_pkg::addr_t];
    logic [7:0]                memory [mem_bus_pkg::addr_t];
    // loads waiting for a miss result
    cache_pkg::req_id_t        open_ids [$];
    mem_bus_pkg::word_t        open_words [$];
    // fills the memory still owes
    mem_bus_pkg::mem_tag_t     fly_tag [$];
    mem_bus_pkg::addr_t        fly_addr [$];
    int                        fly_due [$];
    logic                      tag_busy [tag_count];

    dcache_top dut0 (.*);

    always #20 clock = ~clock;

    function automatic logic [7:0] fill_byte(mem_bus_pkg::addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] golden_byte(mem_bus_pkg::addr_t a);
        return golden.exists(a) ? golden[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] memory_byte(mem_bus_pkg::addr_t a);
        return memory.exists(a) ? memory[a] : fill_byte(a);
    endfunction

    // reference: aligned little-endian word from the golden model
    function automatic mem_bus_pkg::word_t expected_word(mem_bus_pkg::addr_t a);
        mem_bus_pkg::addr_t base;
        base = {a[31:2], 2'b00};
        return {golden_byte(base + 3), golden_byte(base + 2),
                golden_byte(base + 1), golden_byte(base)};
    endfunction

    task automatic apply_store(mem_bus_pkg::mem_size_e size, mem_bus_pkg::addr_t a,
                               mem_bus_pkg::word_t data);
        mem_bus_pkg::addr_t base;
        int                 n;
        case (size)
            mem_bus_pkg::size_byte: begin
                base = a;
                n    = 1;
            end
            mem_bus_pkg::size_half: begin
                base = {a[31:1], 1'b0};
                n    = 2;
            end
            default: begin
                base = {a[31:2], 2'b00};
                n    = 4;
            end
        endcase
        for (int i = 0; i < n; i++) begin
            golden[mem_bus_pkg::addr_t'(base + i)] = data[8*i +: 8];
        end
    endtask

    task automatic fail_plain(string msg);
        $display("%0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(string name, mem_bus_pkg::word_t expected,
                              mem_bus_pkg::word_t actual);
        if (expected !== actual) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_id(string name, cache_pkg::req_id_t expected,
                            cache_pkg::req_id_t actual);
        if (expected !== actual) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "id mismatch");
        end
    endtask

    task automatic take_response();
        int found;
        found = -1;
        foreach (open_ids[i]) begin
            if (found < 0 && open_ids[i] == miss_resp_id) begin
                found = i;
            end
        end
        if (found < 0) begin
            if (open_ids.size() == 0) begin
                fail_plain("miss result arrived with no load outstanding");
            end
            check_id("miss_resp_id", open_ids[0], miss_resp_id);
        end
        check_word("miss_resp_data", open_words[found], miss_resp_data);
        open_ids.delete(found);
        open_words.delete(found);
    endtask

    // compare process, sampled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (req_valid && !req_accept) begin
                refusals++;
            end
            if (req_valid && req_accept) begin
                if (req_store) begin
                    if (hit_valid) begin
                        fail_plain("hit_valid raised for a store");
                    end
                    apply_store(req_size, req_addr, req_data);
                end else if (hit_valid) begin
                    check_word("hit_data", expected_word(req_addr), hit_data);
                end else if (want_hit) begin
                    fail_plain("load to a filled line did not hit");
                end else begin
                    open_ids.push_back(req_id);
                    open_words.push_back(expected_word(req_addr));
                end
            end
            if (miss_resp_valid) begin
                take_response();
            end
        end
    end

    // memory model
    always @(posedge clock) begin
        int                    hit_at;
        mem_bus_pkg::mem_tag_t t;
        #2;
        mem_resp_tag = '0;
        mem_data_tag = '0;
        if (!reset) begin
            if (mem_command == mem_bus_pkg::cmd_store) begin
                for (int i = 0; i < `DCACHE_BLOCK_BYTES; i++) begin
                    memory[mem_bus_pkg::addr_t'(mem_addr + i)] = mem_wdata[8*i +: 8];
                end
            end else if (mem_command == mem_bus_pkg::cmd_load) begin
                t = '0;
                for (int i = tag_count - 1; i > 0; i--) begin
                    if (!tag_busy[i]) begin
                        t = mem_bus_pkg::mem_tag_t'(i);
                    end
                end
                tag_busy[t]  = 1'b1;
                mem_resp_tag = t;
                fly_tag.push_back(t);
                fly_addr.push_back(mem_addr);
                fly_due.push_back(cycle + 3 + int'($unsigned($random(seed)) % 6));
            end
            hit_at = -1;
            foreach (fly_due[i]) begin
                if (hit_at < 0 && fly_due[i] <= cycle) begin
                    hit_at = i;
                end
            end
            if (hit_at >= 0) begin
                mem_data_tag = fly_tag[hit_at];
                for (int i = 0; i < `DCACHE_BLOCK_BYTES; i++) begin
                    mem_data[8*i +: 8] = memory_byte(mem_bus_pkg::addr_t'(fly_addr[hit_at] + i));
                end
                tag_busy[fly_tag[hit_at]] = 1'b0;
                fly_tag.delete(hit_at);
                fly_addr.delete(hit_at);
                fly_due.delete(hit_at);
            end
        end
    end

    always @(posedge clock) begin
        cycle++;
        if (cycle > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // holds the request until accepted
    task automatic issue(logic store, mem_bus_pkg::mem_size_e size, mem_bus_pkg::addr_t a,
                         mem_bus_pkg::word_t data);
        req_valid = 1'b1;
        req_store = store;
        req_size  = size;
        req_addr  = a;
        req_data  = data;
        req_id    = next_id;
        next_id   = next_id + 1'b1;
        @(negedge clock);
        while (!req_accept) begin
            @(negedge clock);
        end
        @(posedge clock);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (open_ids.size() != 0) begin
            @(negedge clock);
        end
        @(posedge clock);
        #2;
    endtask

    initial begin
        mem_bus_pkg::addr_t a;
        mem_bus_pkg::mem_size_e size;
        seed         = 53;
        clock        = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_size     = mem_bus_pkg::size_word;
        req_addr     = '0;
        req_data     = '0;
        req_id       = '0;
        mem_resp_tag = '0;
        mem_data_tag = '0;
        mem_data     = '0;
        want_hit     = 1'b0;
        next_id      = '0;
        cycle        = 0;
        refusals     = 0;
        foreach (tag_busy[i]) begin
            tag_busy[i] = 1'b0;
        end
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;

        // load miss, then hits on the filled line
        issue(1'b0, mem_bus_pkg::size_word, 32'h40, '0);
        wait_idle();
        want_hit = 1'b1;
        issue(1'b0, mem_bus_pkg::size_word, 32'h44, '0);
        issue(1'b1, mem_bus_pkg::size_byte, 32'h41, 32'h000000ab);
        issue(1'b1, mem_bus_pkg::size_half, 32'h42, 32'h0000cdef);
        issue(1'b1, mem_bus_pkg::size_word, 32'h44, 32'h12345678);
        issue(1'b0, mem_bus_pkg::size_word, 32'h40, '0);
        issue(1'b0, mem_bus_pkg::size_word, 32'h44, '0);
        want_hit = 1'b0;

        // store misses of each size
        issue(1'b1, mem_bus_pkg::size_byte, 32'h203, 32'h00000011);
        issue(1'b1, mem_bus_pkg::size_half, 32'h30a, 32'h00002233);
        issue(1'b1, mem_bus_pkg::size_word, 32'h414, 32'h44556677);
        issue(1'b0, mem_bus_pkg::size_word, 32'h200, '0);
        issue(1'b0, mem_bus_pkg::size_word, 32'h308, '0);
        issue(1'b0, mem_bus_pkg::size_word, 32'h414, '0);
        wait_idle();

        // three dirty blocks in set 2 force a write-back
        issue(1'b1, mem_bus_pkg::size_word, 32'h010, 32'hdead0010);
        issue(1'b1, mem_bus_pkg::size_word, 32'h090, 32'hdead0090);
        issue(1'b1, mem_bus_pkg::size_word, 32'h110, 32'hdead0110);
        issue(1'b0, mem_bus_pkg::size_word, 32'h010, '0);
        issue(1'b0, mem_bus_pkg::size_word, 32'h090, '0);
        issue(1'b0, mem_bus_pkg::size_word, 32'h110, '0);
        wait_idle();

        // duplicate block, then five misses for four entries
        issue(1'b0, mem_bus_pkg::size_word, 32'h600, '0);
        refusals_before = refusals;
        issue(1'b0, mem_bus_pkg::size_word, 32'h604, '0);
        if (refusals == refusals_before) begin
            fail_plain("second miss to an outstanding block was not refused");
        end
        for (int i = 1; i <= 4; i++) begin
            issue(1'b0, mem_bus_pkg::size_word, mem_bus_pkg::addr_t'(32'h800 + 8 * i), '0);
        end
        refusals_before = refusals;
        issue(1'b0, mem_bus_pkg::size_word, 32'h828, '0);
        if (refusals == refusals_before) begin
            fail_plain("miss with all four entries busy was not refused");
        end
        wait_idle();

        for (int n = 0; n < random_requests; n++) begin
            size = mem_bus_pkg::mem_size_e'($unsigned($random(seed)) % 3);
            a    = mem_bus_pkg::addr_t'($unsigned($random(seed)) % 512);
            if (size == mem_bus_pkg::size_half) begin
                a[0] = 1'b0;
            end else if (size == mem_bus_pkg::size_word) begin
                a[1:0] = 2'b00;
            end
            issue(1'($random(seed)), size, a, mem_bus_pkg::word_t'($random(seed)));
        end
        wait_idle();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width
`define DCACHE_ADDR_BITS 32

// line geometry
`define DCACHE_BLOCK_BYTES 8
`define DCACHE_SETS 16
// lru is one bit per set, so this stays at 2
`define DCACHE_WAYS 2

`define DCACHE_MISS_ENTRIES 4
`define DCACHE_REQ_ID_BITS 4

// tag value 0 means no transaction
`define DCACHE_MEM_TAG_BITS 4

`define DCACHE_OFFSET_BITS $clog2(`DCACHE_BLOCK_BYTES)
`define DCACHE_INDEX_BITS $clog2(`DCACHE_SETS)
`define DCACHE_MISS_ID_BITS $clog2(`DCACHE_MISS_ENTRIES)

`endif

// File: logic/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module cache_array (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_valid,
    input  logic                   req_store,
    input  mem_bus_pkg::mem_size_e req_size,
    input  mem_bus_pkg::addr_t     req_addr,
    input  mem_bus_pkg::word_t     req_data,
    input  logic                   miss_accept,
    input  mem_bus_pkg::block_t    mem_data,
    refill_if.array                refill,
    output logic                   req_accept,
    output logic                   hit_valid,
    output mem_bus_pkg::word_t     hit_data,
    output logic                   lookup_miss,
    output cache_pkg::tag_t        miss_tag,
    output cache_pkg::index_t      miss_index,
    output cache_pkg::offset_t     miss_offset,
    output logic                   victim_valid,
    output mem_bus_pkg::addr_t     victim_addr,
    output mem_bus_pkg::block_t    victim_data,
    output logic                   miss_resp_valid,
    output cache_pkg::req_id_t     miss_resp_id,
    output mem_bus_pkg::word_t     miss_resp_data
);

    localparam int sets     = `DCACHE_SETS;
    localparam int ways     = `DCACHE_WAYS;
    localparam int off_bits = `DCACHE_OFFSET_BITS;
    localparam int idx_bits = `DCACHE_INDEX_BITS;

    logic                valid [sets][ways];
    logic                dirty [sets][ways];
    cache_pkg::tag_t     tags  [sets][ways];
    mem_bus_pkg::block_t lines [sets][ways];
    // way to replace next
    logic                lru   [sets];

    cache_pkg::tag_t     req_tag;
    cache_pkg::index_t   req_index;
    cache_pkg::offset_t  req_offset;
    logic [ways-1:0]     way_hit;
    logic                hit;
    logic                hit_way;
    logic                lookup;
    logic                fill_way;
    mem_bus_pkg::block_t fill_line;

    function automatic mem_bus_pkg::word_t word_at(mem_bus_pkg::block_t line,
                                                   cache_pkg::offset_t off);
        return line[32*off[off_bits-1:2] +: 32];
    endfunction

    function automatic mem_bus_pkg::block_t merge_store(mem_bus_pkg::block_t line,
                                                        cache_pkg::offset_t off,
                                                        mem_bus_pkg::mem_size_e size,
                                                        mem_bus_pkg::word_t wdata);
        mem_bus_pkg::block_t merged;
        merged = line;
        case (size)
            mem_bus_pkg::size_byte: merged[8*off +: 8] = wdata[7:0];
            mem_bus_pkg::size_half: merged[16*off[off_bits-1:1] +: 16] = wdata[15:0];
            default:                merged[32*off[off_bits-1:2] +: 32] = wdata;
        endcase
        return merged;
    endfunction

    assign req_tag    = req_addr[`DCACHE_ADDR_BITS-1:off_bits+idx_bits];
    assign req_index  = req_addr[off_bits+idx_bits-1:off_bits];
    assign req_offset = req_addr[off_bits-1:0];

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_hit[w] = valid[req_index][w] && tags[req_index][w] == req_tag;
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    // the fill owns the arrays for its cycle
    assign lookup  = req_valid && !refill.fill;

    assign req_accept  = lookup && (hit || miss_accept);
    assign hit_valid   = lookup && hit && !req_store;
    assign hit_data    = word_at(lines[req_index][hit_way], req_offset);
    assign lookup_miss = lookup && !hit;
    assign miss_tag    = req_tag;
    assign miss_index  = req_index;
    assign miss_offset = req_offset;

    assign fill_way  = lru[refill.fill_index];
    assign fill_line = refill.target_store ?
        merge_store(mem_data, refill.target_offset, refill.target_size, refill.target_data) :
        mem_data;

    assign victim_valid = refill.fill && valid[refill.fill_index][fill_way] &&
                          dirty[refill.fill_index][fill_way];
    assign victim_addr  = {tags[refill.fill_index][fill_way], refill.fill_index,
                           {off_bits{1'b0}}};
    assign victim_data  = lines[refill.fill_index][fill_way];

    assign miss_resp_valid = refill.fill && !refill.target_store;
    assign miss_resp_id    = refill.target_id;
    assign miss_resp_data  = word_at(mem_data, refill.target_offset);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < sets; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < ways; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else if (refill.fill) begin
            valid[refill.fill_index][fill_way] <= 1'b1;
            dirty[refill.fill_index][fill_way] <= refill.target_store;
            lru[refill.fill_index]             <= ~fill_way;
        end else if (lookup && hit) begin
            lru[req_index] <= ~hit_way;
            if (req_store) begin
                dirty[req_index][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (refill.fill) begin
            tags[refill.fill_index][fill_way]  <= refill.fill_tag;
            lines[refill.fill_index][fill_way] <= fill_line;
        end else if (lookup && hit && req_store) begin
            lines[req_index][hit_way] <=
                merge_store(lines[req_index][hit_way], req_offset, req_size, req_data);
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package cache_pkg;

    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-`DCACHE_OFFSET_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_BITS-1:0] offset_t;

    // slot number inside the miss table
    typedef logic [`DCACHE_MISS_ID_BITS-1:0] miss_id_t;

    // echoed back with a miss result
    typedef logic [`DCACHE_REQ_ID_BITS-1:0] req_id_t;

    typedef enum logic [1:0] {
        state_invalid,
        state_pending,
        state_wait_data
    } miss_state_e;

endpackage

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      req_valid,
    input  logic                      req_store,
    input  mem_bus_pkg::mem_size_e    req_size,
    input  mem_bus_pkg::addr_t        req_addr,
    input  mem_bus_pkg::word_t        req_data,
    input  cache_pkg::req_id_t        req_id,
    output logic                      req_accept,
    output logic                      hit_valid,
    output mem_bus_pkg::word_t        hit_data,
    output logic                      miss_resp_valid,
    output cache_pkg::req_id_t        miss_resp_id,
    output mem_bus_pkg::word_t        miss_resp_data,
    output mem_bus_pkg::mem_command_e mem_command,
    output mem_bus_pkg::addr_t        mem_addr,
    output mem_bus_pkg::block_t       mem_wdata,
    input  mem_bus_pkg::mem_tag_t     mem_resp_tag,
    input  mem_bus_pkg::mem_tag_t     mem_data_tag,
    input  mem_bus_pkg::block_t       mem_data
);

    logic                lookup_miss;
    logic                miss_accept;
    cache_pkg::tag_t     miss_tag;
    cache_pkg::index_t   miss_index;
    cache_pkg::offset_t  miss_offset;
    logic                miss_request;
    logic                miss_granted;
    mem_bus_pkg::addr_t  miss_addr;
    logic                victim_valid;
    mem_bus_pkg::addr_t  victim_addr;
    mem_bus_pkg::block_t victim_data;

    refill_if refill ();

    cache_array array0 (
        .clock(clock),
        .reset(reset),
        .req_valid(req_valid),
        .req_store(req_store),
        .req_size(req_size),
        .req_addr(req_addr),
        .req_data(req_data),
        .miss_accept(miss_accept),
        .mem_data(mem_data),
        .refill(refill.array),
        .req_accept(req_accept),
        .hit_valid(hit_valid),
        .hit_data(hit_data),
        .lookup_miss(lookup_miss),
        .miss_tag(miss_tag),
        .miss_index(miss_index),
        .miss_offset(miss_offset),
        .victim_valid(victim_valid),
        .victim_addr(victim_addr),
        .victim_data(victim_data),
        .miss_resp_valid(miss_resp_valid),
        .miss_resp_id(miss_resp_id),
        .miss_resp_data(miss_resp_data)
    );

    miss_table table0 (
        .clock(clock),
        .reset(reset),
        .lookup_miss(lookup_miss),
        .miss_tag(miss_tag),
        .miss_index(miss_index),
        .miss_offset(miss_offset),
        .req_store(req_store),
        .req_size(req_size),
        .req_data(req_data),
        .req_id(req_id),
        .miss_granted(miss_granted),
        .mem_resp_tag(mem_resp_tag),
        .mem_data_tag(mem_data_tag),
        .miss_accept(miss_accept),
        .miss_request(miss_request),
        .miss_addr(miss_addr),
        .refill(refill.tbl)
    );

    mem_port port0 (
        .clock(clock),
        .reset(reset),
        .victim_valid(victim_valid),
        .victim_addr(victim_addr),
        .victim_data(victim_data),
        .miss_request(miss_request),
        .miss_addr(miss_addr),
        .miss_granted(miss_granted),
        .mem_command(mem_command),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// File: logic/mem_bus_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package mem_bus_pkg;

    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [8*`DCACHE_BLOCK_BYTES-1:0] block_t;
    typedef logic [`DCACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_load,
        cmd_store
    } mem_command_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

endpackage

`default_nettype wire

// File: logic/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      victim_valid,
    input  mem_bus_pkg::addr_t        victim_addr,
    input  mem_bus_pkg::block_t       victim_data,
    input  logic                      miss_request,
    input  mem_bus_pkg::addr_t        miss_addr,
    output logic                      miss_granted,
    output mem_bus_pkg::mem_command_e mem_command,
    output mem_bus_pkg::addr_t        mem_addr,
    output mem_bus_pkg::block_t       mem_wdata
);

    // one-entry write-back buffer, drained the cycle after it loads
    logic                wb_valid;
    mem_bus_pkg::addr_t  wb_addr;
    mem_bus_pkg::block_t wb_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= victim_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (victim_valid) begin
            wb_addr <= victim_addr;
            wb_data <= victim_data;
        end
    end

    // write-back goes first
    assign miss_granted = miss_request && !wb_valid;
    assign mem_addr     = wb_valid ? wb_addr : miss_addr;
    assign mem_wdata    = wb_data;

    always_comb begin
        if (wb_valid) begin
            mem_command = mem_bus_pkg::cmd_store;
        end else if (miss_request) begin
            mem_command = mem_bus_pkg::cmd_load;
        end else begin
            mem_command = mem_bus_pkg::cmd_none;
        end
    end

endmodule

`default_nettype wire

// File: logic/miss_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module miss_table (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   lookup_miss,
    input  cache_pkg::tag_t        miss_tag,
    input  cache_pkg::index_t      miss_index,
    input  cache_pkg::offset_t     miss_offset,
    input  logic                   req_store,
    input  mem_bus_pkg::mem_size_e req_size,
    input  mem_bus_pkg::word_t     req_data,
    input  cache_pkg::req_id_t     req_id,
    input  logic                   miss_granted,
    input  mem_bus_pkg::mem_tag_t  mem_resp_tag,
    input  mem_bus_pkg::mem_tag_t  mem_data_tag,
    output logic                   miss_accept,
    output logic                   miss_request,
    output mem_bus_pkg::addr_t     miss_addr,
    refill_if.tbl                  refill
);

    localparam int entries = `DCACHE_MISS_ENTRIES;

    cache_pkg::miss_state_e state [entries];

    cache_pkg::tag_t        entry_tag     [entries];
    cache_pkg::index_t      entry_index   [entries];
    mem_bus_pkg::mem_tag_t  entry_mem_tag [entries];
    logic                   entry_store   [entries];
    mem_bus_pkg::mem_size_e entry_size    [entries];
    cache_pkg::offset_t     entry_offset  [entries];
    mem_bus_pkg::word_t     entry_data    [entries];
    cache_pkg::req_id_t     entry_id      [entries];

    logic                duplicate;
    logic                free_found;
    logic                pend_found;
    logic                fill_found;
    logic                mem_took;
    cache_pkg::miss_id_t free_id;
    cache_pkg::miss_id_t pend_id;
    cache_pkg::miss_id_t fill_id;

    // walk downward so the lowest index wins
    always_comb begin
        duplicate  = 1'b0;
        free_found = 1'b0;
        pend_found = 1'b0;
        fill_found = 1'b0;
        free_id    = '0;
        pend_id    = '0;
        fill_id    = '0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (state[i] == cache_pkg::state_invalid) begin
                free_found = 1'b1;
                free_id    = cache_pkg::miss_id_t'(i);
            end else if (entry_tag[i] == miss_tag && entry_index[i] == miss_index) begin
                duplicate = 1'b1;
            end
            if (state[i] == cache_pkg::state_pending) begin
                pend_found = 1'b1;
                pend_id    = cache_pkg::miss_id_t'(i);
            end
            if (state[i] == cache_pkg::state_wait_data && mem_data_tag != '0 &&
                entry_mem_tag[i] == mem_data_tag) begin
                fill_found = 1'b1;
                fill_id    = cache_pkg::miss_id_t'(i);
            end
        end
    end

    assign miss_accept  = lookup_miss && free_found && !duplicate;
    assign miss_request = pend_found;
    assign miss_addr    = {entry_tag[pend_id], entry_index[pend_id], {`DCACHE_OFFSET_BITS{1'b0}}};
    assign mem_took     = miss_granted && mem_resp_tag != '0;

    assign refill.fill          = fill_found;
    assign refill.fill_tag      = entry_tag[fill_id];
    assign refill.fill_index    = entry_index[fill_id];
    assign refill.target_store  = entry_store[fill_id];
    assign refill.target_size   = entry_size[fill_id];
    assign refill.target_offset = entry_offset[fill_id];
    assign refill.target_data   = entry_data[fill_id];
    assign refill.target_id     = entry_id[fill_id];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                state[i] <= cache_pkg::state_invalid;
            end
        end else begin
            for (int i = 0; i < entries; i++) begin
                case (state[i])
                    cache_pkg::state_invalid: begin
                        if (miss_accept && free_id == cache_pkg::miss_id_t'(i)) begin
                            state[i] <= cache_pkg::state_pending;
                        end
                    end
                    cache_pkg::state_pending: begin
                        if (mem_took && pend_id == cache_pkg::miss_id_t'(i)) begin
                            state[i] <= cache_pkg::state_wait_data;
                        end
                    end
                    cache_pkg::state_wait_data: begin
                        if (fill_found && fill_id == cache_pkg::miss_id_t'(i)) begin
                            state[i] <= cache_pkg::state_invalid;
                        end
                    end
                    default: state[i] <= cache_pkg::state_invalid;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss_accept) begin
            entry_tag[free_id]    <= miss_tag;
            entry_index[free_id]  <= miss_index;
            entry_store[free_id]  <= req_store;
            entry_size[free_id]   <= req_size;
            entry_offset[free_id] <= miss_offset;
            entry_data[free_id]   <= req_data;
            entry_id[free_id]     <= req_id;
        end
        if (mem_took) begin
            entry_mem_tag[pend_id] <= mem_resp_tag;
        end
    end

endmodule

`default_nettype wire

// File: logic/refill_if.sv
`timescale 1ns/1ps
`default_nettype none

// completed fill plus the single target waiting on it
interface refill_if;

    logic                   fill;
    cache_pkg::tag_t        fill_tag;
    cache_pkg::index_t      fill_index;
    logic                   target_store;
    mem_bus_pkg::mem_size_e target_size;
    cache_pkg::offset_t     target_offset;
    mem_bus_pkg::word_t     target_data;
    cache_pkg::req_id_t     target_id;

    modport tbl (
        output fill, fill_tag, fill_index,
        output target_store, target_size, target_offset, target_data, target_id
    );

    modport array (
        input fill, fill_tag, fill_index,
        input target_store, target_size, target_offset, target_data, target_id
    );

endinterface

`default_nettype wire
